//--- hdl/ex_isa_pkg.sv
/*
 * Execute stage instruction encodings
 * Functional unit bit positions, micro-op codes and trap cause width
 */
`default_nettype none

package ex_isa_pkg;

    // Functional unit field
    // --------------------------------------------------
    localparam int FU_W   = 4;                 // One-hot unit select width
    localparam int FU_ALU = 0;                 // Integer ALU
    localparam int FU_LSU = 1;                 // Load/store address gen
    localparam int FU_CFU = 2;                 // Branches and jumps
    localparam int FU_CSR = 3;                 // CSR read/modify/write

    typedef logic [4:0] uop_t;                 // Micro-op, meaning set by fu

    // ALU micro-ops
    // --------------------------------------------------
    localparam uop_t ALU_ADD       = 5'b00001;
    localparam uop_t ALU_SUB       = 5'b00010;
    localparam uop_t ALU_XOR       = 5'b00100;
    localparam uop_t ALU_OR        = 5'b00101;
    localparam uop_t ALU_AND       = 5'b00110;
    localparam uop_t ALU_SLL       = 5'b01000;
    localparam uop_t ALU_SRL       = 5'b01001;
    localparam uop_t ALU_SRA       = 5'b01010;
    localparam uop_t ALU_ROR       = 5'b01011;
    localparam uop_t ALU_SLT       = 5'b01100;
    localparam uop_t ALU_SLTU      = 5'b01101;

    // Control flow micro-ops, [4:3] is 00 cond, 10 jump, 11 resolved
    // --------------------------------------------------
    localparam uop_t CFU_BEQ       = 5'b00001;
    localparam uop_t CFU_BNE       = 5'b00010;
    localparam uop_t CFU_BLT       = 5'b00100;
    localparam uop_t CFU_BGE       = 5'b00101;
    localparam uop_t CFU_BLTU      = 5'b00110;
    localparam uop_t CFU_BGEU      = 5'b00111;
    localparam uop_t CFU_JALI      = 5'b10001; // PC relative, target in opr_c
    localparam uop_t CFU_JALR      = 5'b10010; // Register indirect
    localparam uop_t CFU_NOT_TAKEN = 5'b11000;
    localparam uop_t CFU_TAKEN     = 5'b11001;

    localparam int LSU_LOAD  = 3;              // uop bit marking a load
    localparam int LSU_STORE = 4;              // uop bit marking a store

    localparam int trap_cause_w = 6;
    typedef logic [trap_cause_w-1:0] trap_cause_t;

endpackage

`default_nettype wire

//--- hdl/ex_pipe_pkg.sv
/*
 * Execute stage pipeline structures
 * Word types plus the s2/s3 control and forwarding bundles
 */
`default_nettype none

package ex_pipe_pkg;

    import ex_isa_pkg::*;

    localparam int XLEN = 32;                  // RV32 only

    typedef logic [XLEN-1:0] word_t;           // Operand / result word
    typedef logic [4:0]      reg_addr_t;       // GPR index

    // Control travelling with each instruction
    // --------------------------------------------------
    typedef struct packed {
        reg_addr_t       rd;                   // Destination register
        uop_t            uop;                  // Micro-op code
        logic [FU_W-1:0] fu;                   // One-hot functional unit
        logic            trap;                 // Raise a trap in writeback
        logic [1:0]      size;                 // Instruction size
        logic [31:0]     instr;                // Raw instruction word
    } ex_ctrl_t;

    // Bypass info for the instruction now in execute
    typedef struct packed {
        reg_addr_t rd;                         // Destination register
        word_t     wdata;                      // Value headed for rd
        logic      load;                       // Real data arrives later
        logic      csr;                        // CSR result not yet known
    } ex_fwd_t;

endpackage

`default_nettype wire

//--- hdl/ex_alu.sv
/*
 * Integer ALU
 * Add/sub, logic, shift/rotate and set-less-than, all single cycle.
 * Sum and compare flags are exported for address and branch logic
 */
`timescale 1ns/1ps
`default_nettype none

module ex_alu
    import ex_isa_pkg::*, ex_pipe_pkg::*;
(
    input  wire uop_t  i_uop,                  // Micro-op code
    input  wire word_t i_lhs,                  // Left operand
    input  wire word_t i_rhs,                  // Right operand
    output word_t      o_result,               // Selected ALU result
    output word_t      o_sum,                  // lhs + rhs, always valid
    output logic       o_lt,                   // Signed lhs < rhs
    output logic       o_ltu,                  // Unsigned lhs < rhs
    output logic       o_eq                    // lhs == rhs
);

    word_t             diff;                   // lhs - rhs
    logic [4:0]        shamt;                  // Shift amount, low 5 bits
    logic [2*XLEN-1:0] rot_wide;               // Doubled word for rotate

    // Adders and compares
    // --------------------------------------------------
    assign o_sum = i_lhs + i_rhs;
    assign diff  = i_lhs - i_rhs;
    assign o_eq  = (i_lhs == i_rhs);
    assign o_ltu = (i_lhs < i_rhs);
    assign o_lt  = ($signed(i_lhs) < $signed(i_rhs));

    // Shifter
    // --------------------------------------------------
    assign shamt    = i_rhs[4:0];
    assign rot_wide = {i_lhs, i_lhs} >> shamt; // Low half is the rotate

    always_comb begin
        case (i_uop)
            ALU_ADD:  o_result = o_sum;
            ALU_SUB:  o_result = diff;
            ALU_XOR:  o_result = i_lhs ^ i_rhs;
            ALU_OR:   o_result = i_lhs | i_rhs;
            ALU_AND:  o_result = i_lhs & i_rhs;
            ALU_SLL:  o_result = i_lhs << shamt;
            ALU_SRL:  o_result = i_lhs >> shamt;
            ALU_SRA:  o_result = $signed(i_lhs) >>> shamt;
            ALU_ROR:  o_result = rot_wide[XLEN-1:0];
            ALU_SLT:  o_result = {{(XLEN-1){1'b0}}, o_lt};
            ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, o_ltu};
            default:  o_result = '0;           // Not an ALU op
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/ex_branch_unit.sv
/*
 * Branch resolution
 * Turns a conditional branch into taken/not-taken and forms the jump target
 */
`timescale 1ns/1ps
`default_nettype none

module ex_branch_unit
    import ex_isa_pkg::*, ex_pipe_pkg::*;
(
    input  wire uop_t  i_uop,                  // Incoming CFU micro-op
    input  wire word_t i_opr_c,                // PC relative target
    input  wire word_t i_sum,                  // rs1 + imm from the ALU
    input  wire        i_lt,                   // Signed compare
    input  wire        i_ltu,                  // Unsigned compare
    input  wire        i_eq,                   // Equality
    output uop_t       o_uop,                  // Resolved micro-op
    output word_t      o_target                // Halfword aligned target
);

    logic is_cond;                             // Conditional branch
    logic taken;                               // Condition holds

    always_comb begin
        is_cond = 1'b1;
        taken   = 1'b0;
        case (i_uop)
            CFU_BEQ:  taken = i_eq;
            CFU_BNE:  taken = !i_eq;
            CFU_BLT:  taken = i_lt;
            CFU_BGE:  taken = !i_lt;
            CFU_BLTU: taken = i_ltu;
            CFU_BGEU: taken = !i_ltu;
            default:  is_cond = 1'b0;          // Jumps pass unchanged
        endcase
    end

    assign o_uop = !is_cond ? i_uop :
                   taken    ? CFU_TAKEN : CFU_NOT_TAKEN;

    // JALR target comes off the adder, everything else from opr_c
    assign o_target = (i_uop == CFU_JALR) ? {i_sum[XLEN-1:1], 1'b0} :
                                            {i_opr_c[XLEN-1:1], 1'b0};

endmodule

`default_nettype wire

//--- hdl/ex_result_select.sv
/*
 * Execute result select
 * Picks s3 operands per functional unit, inserts the trap cause and
 * builds the bypass bundle for the decode side
 */
`timescale 1ns/1ps
`default_nettype none

module ex_result_select
    import ex_isa_pkg::*, ex_pipe_pkg::*;
(
    input  wire ex_ctrl_t i_ctrl,              // s2 control
    input  wire word_t    i_opr_a,             // s2 operand A
    input  wire word_t    i_opr_c,             // s2 operand C
    input  wire word_t    i_alu_result,        // ALU result
    input  wire word_t    i_sum,               // a + b
    input  wire word_t    i_target,            // Jump target
    input  wire uop_t     i_cfu_uop,           // Resolved branch uop
    output ex_ctrl_t      o_ctrl,              // Next s3 control
    output word_t         o_opr_a,             // Next s3 operand A
    output word_t         o_opr_b,             // Next s3 operand B
    output logic          o_opr_b_load,        // Operand B is meaningful
    output ex_fwd_t       o_fwd                // Bypass bundle
);

    logic        fu_alu;
    logic        fu_lsu;
    logic        fu_cfu;
    logic        fu_csr;
    logic        lsu_load;
    logic        lsu_store;
    trap_cause_t trap_cause;
    word_t       opr_b_unit;                   // Operand B before trap override

    // Unit decode
    // --------------------------------------------------
    assign fu_alu    = i_ctrl.fu[FU_ALU];
    assign fu_lsu    = i_ctrl.fu[FU_LSU];
    assign fu_cfu    = i_ctrl.fu[FU_CFU];
    assign fu_csr    = i_ctrl.fu[FU_CSR];
    assign lsu_load  = fu_lsu && i_ctrl.uop[LSU_LOAD];
    assign lsu_store = fu_lsu && i_ctrl.uop[LSU_STORE];

    // Operand muxes, fu is one-hot so AND-OR is enough
    // --------------------------------------------------
    assign o_opr_a = ({XLEN{fu_alu}} & i_alu_result) |
                     ({XLEN{fu_lsu}} & i_sum)        |    // Memory address
                     ({XLEN{fu_cfu}} & i_target)     |
                     ({XLEN{fu_csr}} & i_opr_a);          // CSR write data

    assign opr_b_unit = {XLEN{lsu_store || fu_csr}} & i_opr_c;

    // Decode traps carry rd as the cause code
    assign trap_cause   = trap_cause_t'(i_ctrl.rd);
    assign o_opr_b      = i_ctrl.trap ? word_t'(trap_cause) : opr_b_unit;
    assign o_opr_b_load = lsu_store || fu_csr || i_ctrl.trap;

    always_comb begin
        o_ctrl = i_ctrl;
        if (fu_cfu) begin
            o_ctrl.uop = i_cfu_uop;            // Branch outcome to writeback
        end
    end

    assign o_fwd = '{
        rd:    i_ctrl.rd,
        wdata: o_opr_a,
        load:  lsu_load,
        csr:   fu_csr
    };

endmodule

`default_nettype wire

//--- hdl/ex_stage_reg.sv
/*
 * Pipeline register
 * Holds one payload with a valid bit, stalls under busy, clears on flush
 */
`timescale 1ns/1ps
`default_nettype none

module ex_stage_reg #(
    parameter type PAYLOAD_T = logic           // Carried payload
) (
    input  wire           g_clk,
    input  wire           g_resetn,            // Sync, active low
    input  wire           i_load,              // Capture i_data
    input  wire PAYLOAD_T i_data,              // Next payload
    input  wire           i_flush,             // Empty the register
    input  wire           i_busy,              // Downstream stalled
    output PAYLOAD_T      o_data,              // Registered payload
    output logic          o_valid              // o_data holds an instruction
);

    // Flush wins over load, busy freezes everything else
    // --------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            o_data  <= '0;
            o_valid <= 1'b0;
        end else if (!i_busy) begin
            o_valid <= i_load;
            if (i_load) begin
                o_data <= i_data;
            end
        end
    end

    // Flushed instruction never reaches the next stage
    a_flush_empties: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        i_flush |=> !o_valid
    );

endmodule

`default_nettype wire

//--- hdl/ex_execute_stage.sv
/*
 * RV32 execute stage
 * ALU, branch resolution, address and CSR operand forming, then one
 * register stage toward writeback
 */
`timescale 1ns/1ps
`default_nettype none

module ex_execute_stage
    import ex_isa_pkg::*, ex_pipe_pkg::*;
(
    input  wire           g_clk,
    input  wire           g_resetn,            // Sync, active low
    input  wire           i_s2_valid,          // Decode has an instruction
    input  wire ex_ctrl_t i_s2_ctrl,           // Decode control
    input  wire word_t    i_s2_opr_a,          // rs1 or PC
    input  wire word_t    i_s2_opr_b,          // rs2 or immediate
    input  wire word_t    i_s2_opr_c,          // Store data, CSR data, target
    input  wire           i_flush,             // Kill the s3 contents
    input  wire           i_s3_busy,           // Writeback stalled
    output logic          o_s2_busy,           // Stall decode
    output ex_fwd_t       o_fwd,               // Bypass for current s2
    output ex_ctrl_t      o_s3_ctrl,
    output word_t         o_s3_opr_a,
    output word_t         o_s3_opr_b,
    output logic          o_s3_valid
);

    logic     accept;                          // Instruction moves to s3
    word_t    alu_result;
    word_t    alu_sum;
    logic     alu_lt;
    logic     alu_ltu;
    logic     alu_eq;
    uop_t     cfu_uop;
    word_t    cfu_target;
    ex_ctrl_t n_s3_ctrl;
    word_t    n_s3_opr_a;
    word_t    n_s3_opr_b;
    logic     opr_b_load;

    // All units finish in one cycle, only writeback can stall us
    assign o_s2_busy = i_s3_busy;
    assign accept    = i_s2_valid && !o_s2_busy;

    // Units
    // --------------------------------------------------
    ex_alu u_alu (
        .i_uop    (i_s2_ctrl.uop),
        .i_lhs    (i_s2_opr_a),
        .i_rhs    (i_s2_opr_b),
        .o_result (alu_result),
        .o_sum    (alu_sum),
        .o_lt     (alu_lt),
        .o_ltu    (alu_ltu),
        .o_eq     (alu_eq)
    );

    ex_branch_unit u_branch (
        .i_uop    (i_s2_ctrl.uop),
        .i_opr_c  (i_s2_opr_c),
        .i_sum    (alu_sum),
        .i_lt     (alu_lt),
        .i_ltu    (alu_ltu),
        .i_eq     (alu_eq),
        .o_uop    (cfu_uop),
        .o_target (cfu_target)
    );

    ex_result_select u_select (
        .i_ctrl       (i_s2_ctrl),
        .i_opr_a      (i_s2_opr_a),
        .i_opr_c      (i_s2_opr_c),
        .i_alu_result (alu_result),
        .i_sum        (alu_sum),
        .i_target     (cfu_target),
        .i_cfu_uop    (cfu_uop),
        .o_ctrl       (n_s3_ctrl),
        .o_opr_a      (n_s3_opr_a),
        .o_opr_b      (n_s3_opr_b),
        .o_opr_b_load (opr_b_load),
        .o_fwd        (o_fwd)
    );

    // s3 registers
    // --------------------------------------------------
    ex_stage_reg #(.PAYLOAD_T(ex_ctrl_t)) u_reg_ctrl (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_load   (accept),
        .i_data   (n_s3_ctrl),
        .i_flush  (i_flush),
        .i_busy   (i_s3_busy),
        .o_data   (o_s3_ctrl),
        .o_valid  (o_s3_valid)
    );

    ex_stage_reg #(.PAYLOAD_T(word_t)) u_reg_opr_a (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_load   (accept),
        .i_data   (n_s3_opr_a),
        .i_flush  (i_flush),
        .i_busy   (i_s3_busy),
        .o_data   (o_s3_opr_a),
        .o_valid  ()                           // Tracked by u_reg_ctrl
    );

    ex_stage_reg #(.PAYLOAD_T(word_t)) u_reg_opr_b (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_load   (accept && opr_b_load),      // Only stores, CSR, traps
        .i_data   (n_s3_opr_b),
        .i_flush  (i_flush),
        .i_busy   (i_s3_busy),
        .o_data   (o_s3_opr_b),
        .o_valid  ()
    );

    // Checks
    // --------------------------------------------------
    a_s3_hold: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        (o_s3_valid && i_s3_busy && !i_flush) |=>
            (o_s3_valid && $stable(o_s3_ctrl) &&
             $stable(o_s3_opr_a) && $stable(o_s3_opr_b))
    );

    a_fu_onehot: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        accept |-> $onehot(i_s2_ctrl.fu)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
/*
 * Testbench clock and reset source
 * 8 ns clock, reset held low for five cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic g_clk,
    output logic g_resetn
);

    initial begin
        g_clk = 1'b0;
        forever #4 g_clk = ~g_clk;             // 8 ns period
    end

    initial begin
        g_resetn = 1'b0;
        repeat (5) @(posedge g_clk);
        @(negedge g_clk);                      // Release away from the edge
        g_resetn = 1'b1;
    end

endmodule

`default_nettype wire

//--- testbench/tb_execute_stage.sv
/*
 * Execute stage testbench
 * Directed tests for ALU, branches, LSU/CSR, stall/flush and traps
 */
`timescale 1ns/1ps
`default_nettype none

module tb_execute_stage
    import ex_isa_pkg::*, ex_pipe_pkg::*;
;

    localparam int TIMEOUT = 20;               // Cycles per wait

    logic     g_clk;
    logic     g_resetn;
    logic     i_s2_valid;
    ex_ctrl_t i_s2_ctrl;
    word_t    i_s2_opr_a;
    word_t    i_s2_opr_b;
    word_t    i_s2_opr_c;
    logic     i_flush;
    logic     i_s3_busy;
    logic     o_s2_busy;
    ex_fwd_t  o_fwd;
    ex_ctrl_t o_s3_ctrl;
    word_t    o_s3_opr_a;
    word_t    o_s3_opr_b;
    logic     o_s3_valid;

    ex_fwd_t  fwd_seen;                        // o_fwd sampled before accept
    integer   seed;
    int       errors;
    int       tests;

    tb_clock_gen u_clk (.g_clk(g_clk), .g_resetn(g_resetn));

    ex_execute_stage DUT (
        .g_clk(g_clk), .g_resetn(g_resetn), .i_s2_valid(i_s2_valid),
        .i_s2_ctrl(i_s2_ctrl), .i_s2_opr_a(i_s2_opr_a), .i_s2_opr_b(i_s2_opr_b),
        .i_s2_opr_c(i_s2_opr_c), .i_flush(i_flush), .i_s3_busy(i_s3_busy),
        .o_s2_busy(o_s2_busy), .o_fwd(o_fwd), .o_s3_ctrl(o_s3_ctrl),
        .o_s3_opr_a(o_s3_opr_a), .o_s3_opr_b(o_s3_opr_b), .o_s3_valid(o_s3_valid)
    );

    // Reference rules
    // --------------------------------------------------
    function automatic word_t alu_expect(input uop_t op, input word_t a, input word_t b);
        int unsigned sh;
        word_t       r;
        sh = b[4:0];
        case (op)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a + ~b + 32'd1;      // Two's complement subtract
            ALU_XOR:  r = a ^ b;
            ALU_OR:   r = a | b;
            ALU_AND:  r = a & b;
            ALU_SLL:  r = a << sh;
            ALU_SRL:  r = a >> sh;
            ALU_SRA:  r = a[31] ? ((a >> sh) | ~(32'hffff_ffff >> sh)) : (a >> sh);
            ALU_ROR:  r = (sh == 0) ? a : ((a >> sh) | (a << (32 - sh)));
            ALU_SLT:  r = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
            default:  r = 'x;
        endcase
        return r;
    endfunction

    // Signed compare done by flipping the sign bits
    function automatic logic branch_taken(input uop_t op, input word_t a, input word_t b);
        logic slt;
        slt = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
        case (op)
            CFU_BEQ:  return a == b;
            CFU_BNE:  return a != b;
            CFU_BLT:  return slt;
            CFU_BGE:  return !slt;
            CFU_BLTU: return a < b;
            default:  return a >= b;           // BGEU
        endcase
    endfunction

    function automatic ex_ctrl_t make_ctrl(input int fu_bit, input uop_t op,
                                           input reg_addr_t rd, input logic trap);
        ex_ctrl_t c;
        c       = '0;
        c.rd    = rd;
        c.uop   = op;
        c.fu    = 4'b0001 << fu_bit;           // One-hot unit
        c.trap  = trap;
        c.size  = 2'b11;
        c.instr = $random(seed);
        return c;
    endfunction

    // Drive and check helpers
    // --------------------------------------------------
    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Present one instruction, wait for it in s3
    task automatic issue(input ex_ctrl_t ctrl, input word_t a, input word_t b,
                         input word_t c);
        int cycles;
        cycles     = 0;
        i_s2_ctrl  = ctrl;
        i_s2_opr_a = a;
        i_s2_opr_b = b;
        i_s2_opr_c = c;
        i_s2_valid = 1'b1;
        #1 fwd_seen = o_fwd;                   // Combinational bypass
        do begin
            @(negedge g_clk);
            i_s2_valid = 1'b0;
            cycles++;
        end while (!o_s3_valid && cycles < TIMEOUT);
        assert (o_s3_valid && cycles == 1) else begin
            $display("o_s3_valid did not rise one cycle after accept (%0d cycles)", cycles);
            errors++;
        end
    endtask

    task automatic report(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) $display("%s: ok", name);
        else $display("%s: %0d errors", name, errors - errs_before);
    endtask

    // Tests
    // --------------------------------------------------
    task automatic reset_values();
        int e;
        int cycles;
        e      = errors;
        cycles = 0;
        while (g_resetn !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge g_clk);
            cycles++;
        end
        assert (g_resetn === 1'b1) else begin
            $display("Reset was never released");
            errors++;
        end
        check_word("o_s3_valid", word_t'(o_s3_valid), 32'd0);
        check_word("o_s3_opr_a", o_s3_opr_a, 32'd0);
        report("reset_values", e);
    endtask

    task automatic alu_ops();
        uop_t  ops [11];
        word_t a;
        word_t b;
        int    e;
        ops = '{ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL,
                ALU_SRA, ALU_ROR, ALU_SLT, ALU_SLTU};
        e   = errors;
        for (int i = 0; i < 11; i++) begin
            for (int n = 0; n < 4; n++) begin
                a = $random(seed);
                b = $random(seed);
                issue(make_ctrl(FU_ALU, ops[i], 5'd1, 1'b0), a, b, 32'd0);
                check_word("o_s3_opr_a", o_s3_opr_a, alu_expect(ops[i], a, b));
            end
        end
        report("alu_ops", e);
    endtask

    task automatic branch_ops();
        uop_t  conds [6];
        word_t lhs   [6];
        word_t rhs   [6];
        word_t a;
        word_t b;
        word_t c;
        int    e;
        conds = '{CFU_BEQ, CFU_BNE, CFU_BLT, CFU_BGE, CFU_BLTU, CFU_BGEU};
        lhs   = '{32'd5, 32'd3, 32'd9, 32'hffff_ffff, 32'd1, 32'h8000_0000};
        rhs   = '{32'd5, 32'd9, 32'd3, 32'd1, 32'hffff_ffff, 32'h7fff_ffff};
        e     = errors;
        for (int i = 0; i < 6; i++) begin
            for (int p = 0; p < 6; p++) begin
                issue(make_ctrl(FU_CFU, conds[i], 5'd0, 1'b0), lhs[p], rhs[p], 32'h100);
                check_word("o_s3_ctrl.uop", word_t'(o_s3_ctrl.uop),
                           branch_taken(conds[i], lhs[p], rhs[p]) ? CFU_TAKEN : CFU_NOT_TAKEN);
            end
        end
        a = $random(seed);
        b = $random(seed);
        c = $random(seed) | 32'd1;             // Odd target, bit 0 must clear
        issue(make_ctrl(FU_CFU, CFU_JALI, 5'd1, 1'b0), a, b, c);
        check_word("o_s3_ctrl.uop", word_t'(o_s3_ctrl.uop), CFU_JALI);
        check_word("o_s3_opr_a", o_s3_opr_a, c & ~32'd1);
        issue(make_ctrl(FU_CFU, CFU_JALR, 5'd1, 1'b0), a, b, c);
        check_word("o_s3_ctrl.uop", word_t'(o_s3_ctrl.uop), CFU_JALR);
        check_word("o_s3_opr_a", o_s3_opr_a, (a + b) & ~32'd1);
        report("branch_ops", e);
    endtask

    task automatic memory_and_csr();
        word_t a;
        word_t b;
        word_t c;
        int    e;
        a = $random(seed);
        b = $random(seed);
        c = $random(seed);
        e = errors;
        issue(make_ctrl(FU_LSU, 5'b01000, 5'd7, 1'b0), a, b, c);  // Load
        check_word("o_fwd.load", word_t'(fwd_seen.load), 32'd1);
        check_word("o_fwd.rd", word_t'(fwd_seen.rd), 32'd7);
        check_word("o_fwd.wdata", fwd_seen.wdata, a + b);
        check_word("o_s3_opr_a", o_s3_opr_a, a + b);
        issue(make_ctrl(FU_LSU, 5'b10000, 5'd0, 1'b0), a, b, c);  // Store
        check_word("o_s3_opr_a", o_s3_opr_a, a + b);
        check_word("o_s3_opr_b", o_s3_opr_b, c);
        issue(make_ctrl(FU_CSR, 5'b00011, 5'd9, 1'b0), a, b, ~c);
        check_word("o_fwd.csr", word_t'(fwd_seen.csr), 32'd1);
        check_word("o_fwd.wdata", fwd_seen.wdata, a);
        check_word("o_s3_opr_a", o_s3_opr_a, a);
        check_word("o_s3_opr_b", o_s3_opr_b, ~c);
        report("memory_and_csr", e);
    endtask

    task automatic stall_and_flush();
        ex_ctrl_t snap_ctrl;
        word_t    snap_a;
        word_t    snap_b;
        int       e;
        e = errors;
        issue(make_ctrl(FU_ALU, ALU_ADD, 5'd3, 1'b0), 32'd10, 32'd20, 32'd0);
        snap_ctrl  = o_s3_ctrl;
        snap_a     = o_s3_opr_a;
        snap_b     = o_s3_opr_b;
        i_s3_busy  = 1'b1;                     // Writeback stalls
        i_s2_ctrl  = make_ctrl(FU_ALU, ALU_XOR, 5'd4, 1'b0);
        i_s2_opr_a = $random(seed);
        i_s2_valid = 1'b1;
        #1 check_word("o_s2_busy", word_t'(o_s2_busy), 32'd1);
        repeat (3) begin
            @(negedge g_clk);
            check_word("o_s3_valid", word_t'(o_s3_valid), 32'd1);
            check_word("o_s3_ctrl.instr", o_s3_ctrl.instr, snap_ctrl.instr);
            check_word("o_s3_opr_a", o_s3_opr_a, snap_a);
            check_word("o_s3_opr_b", o_s3_opr_b, snap_b);
        end
        i_flush = 1'b1;
        @(negedge g_clk);
        i_flush    = 1'b0;
        i_s3_busy  = 1'b0;
        i_s2_valid = 1'b0;
        check_word("o_s3_valid", word_t'(o_s3_valid), 32'd0);
        check_word("o_s3_opr_a", o_s3_opr_a, 32'd0);
        report("stall_and_flush", e);
    endtask

    task automatic trap_cause();
        int e;
        e = errors;
        issue(make_ctrl(FU_ALU, ALU_ADD, 5'd19, 1'b1), $random(seed), 32'd0, 32'd0);
        check_word("o_s3_ctrl.trap", word_t'(o_s3_ctrl.trap), 32'd1);
        check_word("o_s3_opr_b", o_s3_opr_b, 32'd19);
        report("trap_cause", e);
    endtask

    // Sequence
    // --------------------------------------------------
    initial begin
        seed       = 32'hae08;
        errors     = 0;
        tests      = 0;
        i_s2_valid = 1'b0;
        i_s2_ctrl  = '0;
        i_s2_opr_a = '0;
        i_s2_opr_b = '0;
        i_s2_opr_c = '0;
        i_flush    = 1'b0;
        i_s3_busy  = 1'b0;
        fwd_seen   = '0;
        reset_values();
        alu_ops();
        branch_ops();
        memory_and_csr();
        stall_and_flush();
        trap_cause();
        $display("Summary: %0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
hdl/ex_isa_pkg.sv
hdl/ex_pipe_pkg.sv
hdl/ex_alu.sv
hdl/ex_branch_unit.sv
hdl/ex_result_select.sv
hdl/ex_stage_reg.sv
hdl/ex_execute_stage.sv
testbench/tb_clock_gen.sv
testbench/tb_execute_stage.sv
